//--- verilog/nabp_config.svh
`ifndef NABP_CONFIG_SVH
`define NABP_CONFIG_SVH

// projection angle index width
`define NABP_ANGLE_W 8

// detector index, doubles as bank and host ram address
`define NABP_S_W 5
// detectors per projection
`define NABP_NUM_S 24

// unsigned host sample
`define NABP_RAW_W 12
// signed filtered sample
`define NABP_FILT_W 16

// cycles from address issue to filtered result
`define NABP_FIR_LATENCY 2

`endif

//--- verilog/nabp_pkg.sv
`include "nabp_config.svh"

package nabp_pkg;

    // projection angle index
    typedef logic [`NABP_ANGLE_W-1:0] angle_t;

    // detector position, also used as an address
    typedef logic [`NABP_S_W-1:0] s_t;

    // raw host sample, unsigned
    typedef logic [`NABP_RAW_W-1:0] raw_t;

    // ramp filtered sample, signed
    typedef logic signed [`NABP_FILT_W-1:0] filt_t;

    // ping-pong control states
    typedef enum logic [1:0] {
        ready_s,
        fill_s,
        fill_and_work_s,
        work_s
    } swap_state_t;

endpackage

//--- verilog/nabp_interfaces.sv
`timescale 1ns/1ps

// one filtered ram bank seen from the swap control
interface bank_if;
    import nabp_pkg::*;

    // fill sequencing
    logic  fill_kick;
    logic  fill_done;
    logic  fill_s_valid;
    s_t    fill_s;
    // filtered write port
    logic  wr_valid;
    s_t    wr_s;
    filt_t wr_val;
    // two read ports, 1 cycle latency
    s_t    rd0_s;
    s_t    rd1_s;
    filt_t rd0_val;
    filt_t rd1_val;

    modport control (output fill_kick, wr_valid, wr_s, wr_val, rd0_s, rd1_s,
                     input  fill_done, fill_s_valid, fill_s, rd0_val, rd1_val);
    modport bank    (input  fill_kick, wr_valid, wr_s, wr_val, rd0_s, rd1_s,
                     output fill_done, fill_s_valid, fill_s, rd0_val, rd1_val);
endinterface

// angle handover and reads between swap control and sweep
interface sweep_if;
    import nabp_pkg::*;

    angle_t angle;
    logic   has_angle;
    logic   angle_ack;
    logic   next_angle;
    s_t     rd0_s;
    s_t     rd1_s;
    filt_t  rd0_val;
    filt_t  rd1_val;

    modport control (output angle, has_angle, angle_ack, rd0_val, rd1_val,
                     input  next_angle, rd0_s, rd1_s);
    modport sweep   (input  angle, has_angle, angle_ack, rd0_val, rd1_val,
                     output next_angle, rd0_s, rd1_s);
endinterface

//--- verilog/fir_filter.sv
`timescale 1ns/1ps
`include "nabp_config.svh"

module fir_filter
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic            s_valid,
    input  nabp_pkg::s_t    s_val,
    input  nabp_pkg::raw_t  x,
    output logic            y_valid,
    output nabp_pkg::s_t    y_s,
    output nabp_pkg::filt_t y
);
    import nabp_pkg::*;

    // address delayed by one to line up with host data
    logic  a_valid;
    s_t    a_s;
    // sample taken in, padding slot reads as zero
    raw_t  xs;
    // previous two samples
    raw_t  h1;
    raw_t  h2;
    // kernel operands, sign extended
    filt_t c;
    filt_t l;
    filt_t r;

    assign xs = (a_s == s_t'(`NABP_NUM_S)) ? '0 : x;
    assign c  = filt_t'(h1);
    assign l  = filt_t'(h2);
    assign r  = filt_t'(xs);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            a_valid <= 1'b0;
            y_valid <= 1'b0;
        end
        else
        begin
            a_valid <= s_valid;
            // address 0 has no centre to its left yet
            y_valid <= a_valid && (a_s != '0);
        end
    end

    always_ff @(posedge clk)
    begin
        a_s <= s_val;
        if (a_valid)
        begin
            h1 <= xs;
            // start of projection, raw[-1] is zero
            h2 <= (a_s == '0) ? '0 : h1;
        end
        // ramp kernel -1 2 -1 around the previous sample
        y_s <= a_s - 1'b1;
        y   <= (c <<< 1) - l - r;
    end

endmodule

//--- verilog/filtered_ram_bank.sv
`timescale 1ns/1ps
`include "nabp_config.svh"

module filtered_ram_bank
(
    input logic  clk,
    input logic  reset_n,
    bank_if.bank bus
);
    import nabp_pkg::*;

    // one projection of filtered samples
    filt_t mem [`NABP_NUM_S];

    // fill sequencer
    logic issuing;
    s_t   fill_cnt;
    s_t   wr_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill, addresses 0..N then wait for N writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign bus.fill_s_valid = issuing;
    assign bus.fill_s       = fill_cnt;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            issuing       <= 1'b0;
            fill_cnt      <= '0;
            wr_cnt        <= '0;
            bus.fill_done <= 1'b1;
        end
        else if (bus.fill_kick)
        begin
            issuing       <= 1'b1;
            fill_cnt      <= '0;
            wr_cnt        <= '0;
            bus.fill_done <= 1'b0;
        end
        else
        begin
            // N is the padding address that flushes the filter
            if (issuing)
            begin
                if (fill_cnt == s_t'(`NABP_NUM_S))
                    issuing <= 1'b0;
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (bus.wr_valid && !bus.fill_done)
            begin
                wr_cnt <= wr_cnt + 1'b1;
                // last centre written
                if (wr_cnt == s_t'(`NABP_NUM_S - 1))
                    bus.fill_done <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and registered reads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (bus.wr_valid && !bus.fill_done)
            mem[bus.wr_s] <= bus.wr_val;
    end

    // out of range reads give zero, sweep relies on filtered[N] = 0
    always_ff @(posedge clk)
    begin
        bus.rd0_val <= (bus.rd0_s < s_t'(`NABP_NUM_S)) ? mem[bus.rd0_s] : '0;
        bus.rd1_val <= (bus.rd1_s < s_t'(`NABP_NUM_S)) ? mem[bus.rd1_s] : '0;
    end

endmodule

//--- verilog/filtered_ram_swap_control.sv
`timescale 1ns/1ps

module filtered_ram_swap_control
(
    input  logic             clk,
    input  logic             reset_n,
    // host angle handshake
    input  nabp_pkg::angle_t hs_angle,
    input  logic             hs_has_next_angle,
    input  logic             hs_next_angle_ack,
    output logic             hs_next_angle,
    // host ram address
    output logic             hs_s_valid,
    output nabp_pkg::s_t     hs_s_val,
    // filter results
    input  logic             flt_valid,
    input  nabp_pkg::s_t     flt_s,
    input  nabp_pkg::filt_t  flt_val,
    // banks and sweep
    bank_if.control          bank0,
    bank_if.control          bank1,
    sweep_if.control         sweep
);
    import nabp_pkg::*;

    swap_state_t state;
    swap_state_t next_state;

    // bank mux and demux select
    //   sw_sel | bank0   | bank1
    //   0      | working | filling
    //   1      | filling | working
    logic sw_sel;

    // filling bank status and kick
    logic fill_done;
    logic fill_kick;

    // swap pulse from rising edge
    logic swap_curr;
    logic swap_prev;
    logic swap;

    // angle loaded into the filling bank
    angle_t fill_angle;
    logic   fill_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bank routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fill_done = sw_sel ? bank0.fill_done : bank1.fill_done;
    // kick lands on the bank that fills after the toggle
    assign bank0.fill_kick = sw_sel ? 1'b0 : fill_kick;
    assign bank1.fill_kick = sw_sel ? fill_kick : 1'b0;

    // filling bank addresses the host ram
    assign hs_s_valid = sw_sel ? bank0.fill_s_valid : bank1.fill_s_valid;
    assign hs_s_val   = sw_sel ? bank0.fill_s : bank1.fill_s;

    // filter writes only to the filling bank
    assign bank0.wr_valid = sw_sel && flt_valid;
    assign bank1.wr_valid = !sw_sel && flt_valid;
    assign bank0.wr_s     = flt_s;
    assign bank1.wr_s     = flt_s;
    assign bank0.wr_val   = flt_val;
    assign bank1.wr_val   = flt_val;

    // sweep reads, data from working bank
    assign bank0.rd0_s  = sweep.rd0_s;
    assign bank0.rd1_s  = sweep.rd1_s;
    assign bank1.rd0_s  = sweep.rd0_s;
    assign bank1.rd1_s  = sweep.rd1_s;
    assign sweep.rd0_val = sw_sel ? bank1.rd0_val : bank0.rd0_val;
    assign sweep.rd1_val = sw_sel ? bank1.rd1_val : bank0.rd1_val;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mealy outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ask for an angle when idle, or when fill and sweep are both finished
    assign hs_next_angle = (state == ready_s) ||
                           (((state == fill_s) || (state == fill_and_work_s)) &&
                            fill_done && sweep.next_angle);
    // end-of-stream ack in ready_s changes nothing
    assign swap_curr = hs_next_angle && hs_next_angle_ack &&
                       (hs_has_next_angle || (state != ready_s));
    assign swap      = swap_curr && !swap_prev;
    assign fill_kick = swap && (next_state != work_s);
    // a finished fill goes to the sweep, except on the first angle
    assign sweep.angle_ack = swap && (state != ready_s);

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (swap)
                    next_state = fill_s;
            fill_s, fill_and_work_s:
                if (swap)
                    next_state = hs_has_next_angle ? fill_and_work_s : work_s;
            work_s:
                if (sweep.next_angle)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state           <= ready_s;
            sw_sel          <= 1'b0;
            swap_prev       <= 1'b0;
            fill_valid      <= 1'b0;
            sweep.has_angle <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            swap_prev <= swap_curr;
            if (swap)
                sw_sel <= !sw_sel;
            if (fill_kick)
                fill_valid <= 1'b1;
            else if (sweep.angle_ack)
                fill_valid <= 1'b0;
            if (sweep.angle_ack)
                sweep.has_angle <= fill_valid;
        end
    end

    // angle bookkeeping, filling angle moves to the sweep on the swap
    always_ff @(posedge clk)
    begin
        if (fill_kick)
            fill_angle <= hs_angle;
        if (sweep.angle_ack)
            sweep.angle <= fill_angle;
    end

endmodule

//--- verilog/projection_sweep.sv
`timescale 1ns/1ps
`include "nabp_config.svh"

module projection_sweep
(
    input  logic             clk,
    input  logic             reset_n,
    sweep_if.sweep           ctl,
    output logic             out_valid,
    input  logic             out_ready,
    output nabp_pkg::angle_t out_angle,
    output nabp_pkg::s_t     out_s,
    output nabp_pkg::filt_t  out_val
);
    import nabp_pkg::*;

    logic ack_q;
    logic busy;
    // next detector to read
    s_t   s;
    logic issue;
    // read in flight
    logic rd_pending;
    s_t   rd_s;
    // interpolation, one extra bit before the halving
    logic [`NABP_FILT_W:0] sum;
    filt_t interp;
    // skid entry behind the output register
    logic  sk_valid;
    s_t    sk_s;
    filt_t sk_val;
    logic  load;

    assign ctl.rd0_s = s;
    assign ctl.rd1_s = s + 1'b1;
    // only read when the result is sure to find a place
    assign issue = busy && !sk_valid && !(rd_pending && out_valid && !out_ready);
    assign load  = !out_valid || out_ready;

    assign sum    = {ctl.rd0_val[`NABP_FILT_W-1], ctl.rd0_val} +
                    {ctl.rd1_val[`NABP_FILT_W-1], ctl.rd1_val};
    assign interp = sum[`NABP_FILT_W:1];

    // idle once everything has drained
    assign ctl.next_angle = !busy && !ack_q && !rd_pending && !sk_valid && !out_valid;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ack_q      <= 1'b0;
            busy       <= 1'b0;
            s          <= '0;
            rd_pending <= 1'b0;
            sk_valid   <= 1'b0;
            out_valid  <= 1'b0;
        end
        else
        begin
            ack_q      <= ctl.angle_ack;
            rd_pending <= issue;
            // has_angle is valid the cycle after the ack
            if (ack_q && ctl.has_angle)
            begin
                busy <= 1'b1;
                s    <= '0;
            end
            else if (issue)
            begin
                if (s == s_t'(`NABP_NUM_S - 1))
                    busy <= 1'b0;
                s <= s + 1'b1;
            end
            if (load)
            begin
                out_valid <= sk_valid || rd_pending;
                sk_valid  <= sk_valid && rd_pending;
            end
            else if (rd_pending)
                sk_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
            rd_s <= s;
        // skid drains first to keep order
        if (load)
        begin
            out_angle <= ctl.angle;
            out_s     <= sk_valid ? sk_s : rd_s;
            out_val   <= sk_valid ? sk_val : interp;
        end
        if (rd_pending && (sk_valid || !load))
        begin
            sk_s   <= rd_s;
            sk_val <= interp;
        end
    end

endmodule

//--- verilog/nabp_filter_top.sv
`timescale 1ns/1ps

module nabp_filter_top
(
    input  logic             clk,
    input  logic             reset_n,
    // host angle handshake
    input  nabp_pkg::angle_t hs_angle,
    input  logic             hs_has_next_angle,
    input  logic             hs_next_angle_ack,
    output logic             hs_next_angle,
    // host ram
    output logic             hs_s_valid,
    output nabp_pkg::s_t     hs_s_val,
    input  nabp_pkg::raw_t   hs_raw,
    // interpolated output stream
    output logic             out_valid,
    input  logic             out_ready,
    output nabp_pkg::angle_t out_angle,
    output nabp_pkg::s_t     out_s,
    output nabp_pkg::filt_t  out_val
);
    import nabp_pkg::*;

    // filter to swap control
    logic  flt_valid;
    s_t    flt_s;
    filt_t flt_val;

    bank_if  bank0_bus ();
    bank_if  bank1_bus ();
    sweep_if sweep_bus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host ram, filter, ping-pong banks, sweep
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fir_filter fir_filter_i
    (
        .clk     (clk),
        .reset_n (reset_n),
        .s_valid (hs_s_valid),
        .s_val   (hs_s_val),
        .x       (hs_raw),
        .y_valid (flt_valid),
        .y_s     (flt_s),
        .y       (flt_val)
    );

    filtered_ram_swap_control swap_control_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_next_angle     (hs_next_angle),
        .hs_s_valid        (hs_s_valid),
        .hs_s_val          (hs_s_val),
        .flt_valid         (flt_valid),
        .flt_s             (flt_s),
        .flt_val           (flt_val),
        .bank0             (bank0_bus.control),
        .bank1             (bank1_bus.control),
        .sweep             (sweep_bus.control)
    );

    filtered_ram_bank bank0_i (.clk(clk), .reset_n(reset_n), .bus(bank0_bus.bank));
    filtered_ram_bank bank1_i (.clk(clk), .reset_n(reset_n), .bus(bank1_bus.bank));

    projection_sweep projection_sweep_i
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .ctl       (sweep_bus.sweep),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_angle (out_angle),
        .out_s     (out_s),
        .out_val   (out_val)
    );

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen
(
    output logic clk,
    output logic reset_n
);
    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // reset held for 8 rising edges, released on a falling edge
    initial
    begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

//--- test/nabp_filter_assertions.sv
`timescale 1ns/1ps
`include "nabp_config.svh"

module nabp_filter_assertions
(
    input logic             clk,
    input logic             reset_n,
    input nabp_pkg::angle_t hs_angle,
    input logic             hs_has_next_angle,
    input logic             hs_next_angle_ack,
    input logic             hs_next_angle,
    input logic             hs_s_valid,
    input nabp_pkg::s_t     hs_s_val,
    input logic             out_valid,
    input logic             out_ready,
    input nabp_pkg::angle_t out_angle,
    input nabp_pkg::s_t     out_s,
    input nabp_pkg::filt_t  out_val
);
    import nabp_pkg::*;

    // failed assertions so far, watched by the testbench
    int fail_count = 0;

    // angles in host order
    angle_t     ack_angle [16];
    int         ack_cnt;
    int         beat_cnt;
    // end of stream seen
    logic       ended;
    logic       beat;
    logic       ack;
    logic [3:0] exp_idx;
    angle_t     exp_angle;
    s_t         exp_s;
    filt_t      exp_val;

    // host ram contents, zero outside the detector row
    function automatic int raw_model(int angle, int s);
        if ((s < 0) || (s >= `NABP_NUM_S))
            return 0;
        return (angle * 37 + s * 11) % 4096;
    endfunction

    // ramp kernel, filtered[N] is zero
    function automatic int filt_model(int angle, int s);
        if (s >= `NABP_NUM_S)
            return 0;
        return 2 * raw_model(angle, s) - raw_model(angle, s - 1) - raw_model(angle, s + 1);
    endfunction

    // linear interpolation between s and s+1
    function automatic int out_model(int angle, int s);
        return (filt_model(angle, s) + filt_model(angle, s + 1)) >>> 1;
    endfunction

    assign beat      = out_valid && out_ready;
    assign ack       = hs_next_angle && hs_next_angle_ack;
    assign exp_idx   = 4'(beat_cnt / `NABP_NUM_S);
    assign exp_angle = ack_angle[exp_idx];
    assign exp_s     = s_t'(beat_cnt % `NABP_NUM_S);
    assign exp_val   = filt_t'(out_model(int'(exp_angle), int'(exp_s)));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ack_cnt  <= 0;
            beat_cnt <= 0;
            ended    <= 1'b0;
        end
        else
        begin
            if (ack && hs_has_next_angle)
            begin
                ack_angle[ack_cnt[3:0]] <= hs_angle;
                ack_cnt <= ack_cnt + 1;
            end
            else if (ack)
                ended <= 1'b1;
            if (beat)
                beat_cnt <= beat_cnt + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    reset_state: assert property (@(posedge clk)
        $rose(reset_n) |-> hs_next_angle && !out_valid && !hs_s_valid)
        else begin
            fail_count++;
            $error("handshake and stream outputs not idle after reset");
        end

    out_value: assert property (@(posedge clk) disable iff (!reset_n)
        beat |-> (out_val == exp_val))
        else begin
            fail_count++;
            $error("ERROR out_value angle %0d s %0d: expected %0d, actual %0d",
                   $sampled(exp_angle), $sampled(exp_s), $sampled(exp_val), $sampled(out_val));
        end

    // angle in host order, s counting up, no beat beyond the acked angles
    out_order: assert property (@(posedge clk) disable iff (!reset_n)
        beat |-> (beat_cnt < ack_cnt * `NABP_NUM_S) && (out_angle == exp_angle) &&
                 (out_s == exp_s))
        else begin
            fail_count++;
            $error("ERROR out_order: expected angle %0d s %0d, actual angle %0d s %0d",
                   $sampled(exp_angle), $sampled(exp_s), $sampled(out_angle), $sampled(out_s));
        end

    out_hold: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_angle) && $stable(out_s) &&
                                    $stable(out_val))
        else begin
            fail_count++;
            $error("output beat changed or dropped while stalled");
        end

    // nothing left once every angle is swept after end of stream
    out_drained: assert property (@(posedge clk) disable iff (!reset_n)
        ended && (beat_cnt == ack_cnt * `NABP_NUM_S) |-> !out_valid)
        else begin
            fail_count++;
            $error("output valid after the last angle was swept");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host ram fill addresses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fill_start: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(hs_s_valid) |-> (hs_s_val == '0) && $past(ack && hs_has_next_angle))
        else begin
            fail_count++;
            $error("fill did not start at address 0 right after an angle ack");
        end

    fill_step: assert property (@(posedge clk) disable iff (!reset_n)
        hs_s_valid && (hs_s_val < s_t'(`NABP_NUM_S)) |=>
            hs_s_valid && (hs_s_val == $past(hs_s_val) + 1'b1))
        else begin
            fail_count++;
            $error("fill addresses not consecutive");
        end

    fill_end: assert property (@(posedge clk) disable iff (!reset_n)
        hs_s_valid && (hs_s_val == s_t'(`NABP_NUM_S)) |=> !hs_s_valid)
        else begin
            fail_count++;
            $error("fill kept going after the padding address");
        end

endmodule

bind nabp_filter_top nabp_filter_assertions assertions_i
(
    .clk               (clk),
    .reset_n           (reset_n),
    .hs_angle          (hs_angle),
    .hs_has_next_angle (hs_has_next_angle),
    .hs_next_angle_ack (hs_next_angle_ack),
    .hs_next_angle     (hs_next_angle),
    .hs_s_valid        (hs_s_valid),
    .hs_s_val          (hs_s_val),
    .out_valid         (out_valid),
    .out_ready         (out_ready),
    .out_angle         (out_angle),
    .out_s             (out_s),
    .out_val           (out_val)
);

//--- test/nabp_filter_tb.sv
`timescale 1ns/1ps
`include "nabp_config.svh"

module nabp_filter_tb;
    import nabp_pkg::*;

    localparam int NUM_ANGLES  = 6;
    localparam int NUM_BEATS   = NUM_ANGLES * `NABP_NUM_S;
    // fill plus a sweep stalled four times over, per angle, then margin
    localparam int MAX_CYCLES  = NUM_ANGLES *
                                 (`NABP_NUM_S + 1 + `NABP_FIR_LATENCY + 4 * `NABP_NUM_S) + 250;
    // idle cycles watched after the last beat
    localparam int TAIL_CYCLES = 8;

    logic   clk;
    logic   reset_n;
    angle_t hs_angle;
    logic   hs_has_next_angle;
    logic   hs_next_angle_ack;
    logic   hs_next_angle;
    logic   hs_s_valid;
    s_t     hs_s_val;
    raw_t   hs_raw;
    logic   out_valid;
    logic   out_ready;
    angle_t out_angle;
    s_t     out_s;
    filt_t  out_val;

    clock_gen clock_gen_i (.clk(clk), .reset_n(reset_n));

    nabp_filter_top nabp_filter_top_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_next_angle     (hs_next_angle),
        .hs_s_valid        (hs_s_valid),
        .hs_s_val          (hs_s_val),
        .hs_raw            (hs_raw),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .out_angle         (out_angle),
        .out_s             (out_s),
        .out_val           (out_val)
    );

    // host ram contents of one angle
    function automatic raw_t host_sample(angle_t angle, s_t s);
        return raw_t'((int'(angle) * 37 + int'(s) * 11) % 4096);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host model and back-pressure, all on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        angle_t ram_angle;
        s_t     ram_addr;
        int     acked;
        int     delay;
        logic   acked_last;
        int     beats;
        int     cycle_cnt;
        int     tail;
        logic   stop;

        hs_angle          = '0;
        hs_has_next_angle = 1'b0;
        hs_next_angle_ack = 1'b0;
        hs_raw            = '0;
        out_ready         = 1'b0;
        ram_angle         = '0;
        ram_addr          = '0;
        acked             = 0;
        delay             = -1;
        acked_last        = 1'b0;
        beats             = 0;
        cycle_cnt         = 0;
        tail              = 0;
        stop              = 1'b0;
        void'($urandom(68));

        @(posedge reset_n);
        while (!stop)
        begin
            @(negedge clk);
            cycle_cnt++;
            // data for the address issued one cycle earlier
            hs_raw   = host_sample(ram_angle, ram_addr);
            ram_addr = hs_s_val;
            // ready about 70% of the time
            out_ready = ($urandom_range(0, 9) < 7);
            if (out_valid && out_ready)
                beats++;
            // angle handshake, ack after 0..3 cycles
            hs_next_angle_ack = 1'b0;
            if ((acked <= NUM_ANGLES) && hs_next_angle && !acked_last)
            begin
                if (delay < 0)
                    delay = $urandom_range(0, 3);
                if (delay == 0)
                begin
                    hs_next_angle_ack = 1'b1;
                    hs_has_next_angle = (acked < NUM_ANGLES);
                    hs_angle          = angle_t'($urandom_range(0, 255));
                    // host ram now holds this angle
                    if (acked < NUM_ANGLES)
                        ram_angle = hs_angle;
                    acked++;
                    delay = -1;
                end
                else
                    delay--;
            end
            acked_last = hs_next_angle_ack;
            // all beats out and the request back up
            if ((acked > NUM_ANGLES) && (beats == NUM_BEATS) && hs_next_angle)
                tail++;
            stop = (nabp_filter_top_i.assertions_i.fail_count != 0) ||
                   (cycle_cnt >= MAX_CYCLES) || (tail == TAIL_CYCLES);
        end

        if ((nabp_filter_top_i.assertions_i.fail_count == 0) && (tail == TAIL_CYCLES))
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            if (nabp_filter_top_i.assertions_i.fail_count == 0)
                $display("timeout after %0d cycles with %0d of %0d beats seen",
                         cycle_cnt, beats, NUM_BEATS);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped on the first failure");
        end
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/nabp_pkg.sv
verilog/nabp_interfaces.sv
verilog/fir_filter.sv
verilog/filtered_ram_bank.sv
verilog/filtered_ram_swap_control.sv
verilog/projection_sweep.sv
verilog/nabp_filter_top.sv
test/clock_gen.sv
test/nabp_filter_assertions.sv
test/nabp_filter_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= nabp_filter_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in its output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
